// File: Bender.yml
package:
  name: disp_subsys

sources:
  - design/disp_pkg.sv
  - design/disp_channel_select.sv
  - design/scan_timer.sv
  - design/digit_scanner.sv
  - design/seg_decoder.sv
  - design/disp_subsys.sv
  - target: simulation
    files:
      - verification/disp_subsys_assert.sv
      - verification/disp_subsys_tb.sv

// File: design/digit_scanner.sv
`timescale 1ns/100ps

module digit_scanner import disp_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        scan_tick,
	input  logic        blink_phase,
	input  disp_word_t  disp_num,
	input  digit_mask_t point_mask,
	input  digit_mask_t blink_mask,
	output digit_mask_t an_n,
	output nibble_t     nibble,
	output logic        point,
	output logic        blank
);

	digit_idx_t digit_idx;

	////////////////////
	// Digit index
	////////////////////

	// Wraps from digit 7 back to digit 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			digit_idx <= '0;
		end else if (scan_tick) begin
			digit_idx <= digit_idx + 1'b1;
		end
	end

	// Common anode, so the lit digit is driven low
	assign an_n = ~(digit_mask_t'(1) << digit_idx);

	////////////////////
	// Current digit
	////////////////////

	assign nibble = disp_num[{digit_idx, 2'b00} +: 4];
	assign point  = point_mask[digit_idx];

	// Off half of the blink period
	assign blank  = blink_mask[digit_idx] & blink_phase;

endmodule

// File: design/disp_channel_select.sv
`timescale 1ns/100ps

module disp_channel_select import disp_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cpu_we,
	input  digit_idx_t  test_sel,
	input  logic [63:0] point_in,
	input  logic [63:0] blink_in,
	input  logic [63:0] les,
	input  disp_word_t  data0,
	input  disp_word_t  data1,
	input  disp_word_t  data2,
	input  disp_word_t  data3,
	input  disp_word_t  data4,
	input  disp_word_t  data5,
	input  disp_word_t  data6,
	input  disp_word_t  data7,
	output disp_word_t  disp_num,
	output digit_mask_t point_out,
	output digit_mask_t blink_out
);

	disp_word_t  cpu_num;
	digit_mask_t cpu_blink;
	digit_mask_t cpu_point;

	////////////////////
	// CPU channel 0
	////////////////////

	// Loaded by the write strobe, byte 0 of point and blink is the write data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cpu_num   <= DISP_RESET_WORD;
			cpu_blink <= BLINK_RESET_MASK;
			cpu_point <= POINT_RESET_MASK;
		end else if (cpu_we) begin
			cpu_num   <= data0;
			cpu_blink <= blink_in[7:0];
			cpu_point <= point_in[7:0];
		end
	end

	////////////////////
	// Source select
	////////////////////

	always_comb begin
		case (test_sel)
			3'd0:    disp_num = cpu_num;
			3'd1:    disp_num = data1;
			3'd2:    disp_num = data2;
			3'd3:    disp_num = data3;
			3'd4:    disp_num = data4;
			3'd5:    disp_num = data5;
			3'd6:    disp_num = data6;
			default: disp_num = data7;
		endcase
	end

	// Byte k of the board masks belongs to channel k
	always_comb begin
		if (test_sel == 3'd0) begin
			point_out = cpu_point;
			blink_out = cpu_blink;
		end else begin
			point_out = point_in[{test_sel, 3'b000} +: 8];
			blink_out = les[{test_sel, 3'b000} +: 8];
		end
	end

endmodule

// File: design/disp_pkg.sv
package disp_pkg;

	////////////////////
	// Display types
	////////////////////

	// Eight hex digits, digit 0 in the low nibble
	typedef logic [31:0] disp_word_t;

	// One bit per digit: point, blink or anode
	typedef logic [7:0] digit_mask_t;

	// Single hex digit value
	typedef logic [3:0] nibble_t;

	// Digit position, also the channel select
	typedef logic [2:0] digit_idx_t;

	// Segments a to g, bit 0 is a, active low
	typedef logic [6:0] seg_t;

	////////////////////
	// Channel 0 reset values
	////////////////////

	localparam disp_word_t  DISP_RESET_WORD  = 32'hAA5555AA;
	localparam digit_mask_t BLINK_RESET_MASK = 8'hFF;
	localparam digit_mask_t POINT_RESET_MASK = 8'h00;

	////////////////////
	// Scan and blink timing
	////////////////////

	// Clock cycles per digit
	localparam int SCAN_DIV    = 4;
	localparam int SCAN_CNT_W  = $clog2(SCAN_DIV);

	// Scan ticks per blink half-period
	localparam int BLINK_DIV   = 16;
	localparam int BLINK_CNT_W = $clog2(BLINK_DIV);

endpackage

// File: design/disp_subsys.sv
`timescale 1ns/100ps

module disp_subsys import disp_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cpu_we,
	input  digit_idx_t  test_sel,
	input  logic [63:0] point_in,
	input  logic [63:0] blink_in,
	input  logic [63:0] les,
	input  disp_word_t  data0,
	input  disp_word_t  data1,
	input  disp_word_t  data2,
	input  disp_word_t  data3,
	input  disp_word_t  data4,
	input  disp_word_t  data5,
	input  disp_word_t  data6,
	input  disp_word_t  data7,
	output seg_t        seg_n,
	output logic        dp_n,
	output digit_mask_t an_n
);

	// Selected frame
	disp_word_t  disp_num;
	digit_mask_t point_out;
	digit_mask_t blink_out;

	// Scan timing
	logic        scan_tick;
	logic        blink_phase;

	// Current digit
	nibble_t     nibble;
	logic        point;
	logic        blank;

	disp_channel_select disp_channel_select_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_we    (cpu_we),
		.test_sel  (test_sel),
		.point_in  (point_in),
		.blink_in  (blink_in),
		.les       (les),
		.data0     (data0),
		.data1     (data1),
		.data2     (data2),
		.data3     (data3),
		.data4     (data4),
		.data5     (data5),
		.data6     (data6),
		.data7     (data7),
		.disp_num  (disp_num),
		.point_out (point_out),
		.blink_out (blink_out)
	);

	scan_timer scan_timer_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.scan_tick   (scan_tick),
		.blink_phase (blink_phase)
	);

	digit_scanner digit_scanner_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.scan_tick   (scan_tick),
		.blink_phase (blink_phase),
		.disp_num    (disp_num),
		.point_mask  (point_out),
		.blink_mask  (blink_out),
		.an_n        (an_n),
		.nibble      (nibble),
		.point       (point),
		.blank       (blank)
	);

	seg_decoder seg_decoder_inst (
		.nibble (nibble),
		.point  (point),
		.blank  (blank),
		.seg_n  (seg_n),
		.dp_n   (dp_n)
	);

endmodule

// File: design/scan_timer.sv
`timescale 1ns/100ps

module scan_timer import disp_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	output logic scan_tick,
	output logic blink_phase
);

	logic [SCAN_CNT_W-1:0]  scan_cnt;
	logic [BLINK_CNT_W-1:0] blink_cnt;
	logic                   blink_wrap;

	// Digit prescaler, one tick per SCAN_DIV cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_cnt <= '0;
		end else if (scan_tick) begin
			scan_cnt <= '0;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign scan_tick = (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 1));

	// Last tick of a blink half-period
	assign blink_wrap = scan_tick && (blink_cnt == BLINK_CNT_W'(BLINK_DIV - 1));

	// Phase 0 is visible, phase 1 blanks blinking digits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			blink_cnt   <= '0;
			blink_phase <= 1'b0;
		end else if (blink_wrap) begin
			blink_cnt   <= '0;
			blink_phase <= ~blink_phase;
		end else if (scan_tick) begin
			blink_cnt   <= blink_cnt + 1'b1;
		end
	end

endmodule

// File: design/seg_decoder.sv
`timescale 1ns/100ps

module seg_decoder import disp_pkg::*; (
	input  nibble_t nibble,
	input  logic    point,
	input  logic    blank,
	output seg_t    seg_n,
	output logic    dp_n
);

	seg_t glyph_n;

	// Hex glyphs, bit order g f e d c b a, a low bit lights the segment
	always_comb begin
		case (nibble)
			4'h0:    glyph_n = 7'b1000000;
			4'h1:    glyph_n = 7'b1111001;
			4'h2:    glyph_n = 7'b0100100;
			4'h3:    glyph_n = 7'b0110000;
			4'h4:    glyph_n = 7'b0011001;
			4'h5:    glyph_n = 7'b0010010;
			4'h6:    glyph_n = 7'b0000010;
			4'h7:    glyph_n = 7'b1111000;
			4'h8:    glyph_n = 7'b0000000;
			4'h9:    glyph_n = 7'b0010000;
			4'hA:    glyph_n = 7'b0001000;
			4'hB:    glyph_n = 7'b0000011;
			4'hC:    glyph_n = 7'b1000110;
			4'hD:    glyph_n = 7'b0100001;
			4'hE:    glyph_n = 7'b0000110;
			default: glyph_n = 7'b0001110;
		endcase
	end

	// Blanking turns off the point as well
	assign seg_n = blank ? '1 : glyph_n;
	assign dp_n  = blank | ~point;

endmodule

// File: files.f
design/disp_pkg.sv
design/disp_channel_select.sv
design/scan_timer.sv
design/digit_scanner.sv
design/seg_decoder.sv
design/disp_subsys.sv
verification/disp_subsys_assert.sv
verification/disp_subsys_tb.sv

// File: verification/disp_subsys_assert.sv
`timescale 1ns/100ps

module disp_subsys_assert import disp_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        scan_tick,
	input logic        blink_phase,
	input digit_idx_t  digit_idx,
	input digit_mask_t an_n,
	input logic        blank
);

	int assert_errors = 0;

	// Exactly one anode driven low
	anode_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(~an_n))
		else begin
			assert_errors++;
			$error("anode drive is not one-hot low");
		end

	// A tick moves the index by one and wraps after digit 7
	tick_advance: assert property (@(posedge clk) disable iff (!arst_n)
		scan_tick |=> digit_idx == digit_idx_t'($past(digit_idx) + 1'b1))
		else begin
			assert_errors++;
			$error("digit index did not advance by one on a tick");
		end

	// Blanking only in the off half
	blank_phase: assert property (@(posedge clk) disable iff (!arst_n) blank |-> blink_phase)
		else begin
			assert_errors++;
			$error("blank raised while blink phase is visible");
		end

endmodule

bind digit_scanner disp_subsys_assert scan_assert_inst (.*);

// File: verification/disp_subsys_tb.sv
`timescale 1ns/100ps

module disp_subsys_tb import disp_pkg::*; ();

	localparam int BLINK_LIMIT = 2 * BLINK_DIV * SCAN_DIV * 8;

	logic        clk;
	logic        arst_n;
	logic        cpu_we;
	digit_idx_t  test_sel;
	logic [63:0] point_in;
	logic [63:0] blink_in;
	logic [63:0] les;
	disp_word_t  data [8];
	seg_t        seg_n;
	logic        dp_n;
	digit_mask_t an_n;

	// Reference model state
	string       test_name;
	logic [31:0] lcg_state;
	disp_word_t  m_num;
	digit_mask_t m_point;
	digit_mask_t m_blink;
	digit_mask_t prev_an;
	int          cyc_since;
	logic        scan_seen;
	digit_mask_t seen_on;
	digit_mask_t seen_off;

	disp_subsys disp_subsys_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.cpu_we   (cpu_we),
		.test_sel (test_sel),
		.point_in (point_in),
		.blink_in (blink_in),
		.les      (les),
		.data0    (data[0]),
		.data1    (data[1]),
		.data2    (data[2]),
		.data3    (data[3]),
		.data4    (data[4]),
		.data5    (data[5]),
		.data6    (data[6]),
		.data7    (data[7]),
		.seg_n    (seg_n),
		.dp_n     (dp_n),
		.an_n     (an_n)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	// Lit segments with bit 0 as segment a
	function automatic seg_t glyph_on(nibble_t n);
		case (n)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	// Position of the single low bit or -1 when there is not exactly one
	function automatic int low_bit_index(digit_mask_t an);
		int idx;
		int zeros;
		idx = -1;
		zeros = 0;
		for (int i = 0; i < 8; i++) begin
			if (!an[i]) begin
				idx = i;
				zeros++;
			end
		end
		return (zeros == 1) ? idx : -1;
	endfunction

	task automatic stop_on_error();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic report_failure(string msg);
		$display("%s in %s", msg, test_name);
		stop_on_error();
	endtask

	task automatic drive_inputs(digit_idx_t sel, logic we, logic hold_masks);
		for (int i = 0; i < 8; i++) begin
			data[i] = rand32();
		end
		test_sel = sel;
		cpu_we   = we;
		if (!hold_masks) begin
			point_in = {rand32(), rand32()};
			blink_in = {rand32(), rand32()};
			les      = {rand32(), rand32()};
		end
	endtask

	////////////////////
	// Model and checks
	////////////////////

	// One clock cycle checked at the falling edge before new inputs are driven
	task automatic step();
		disp_word_t  num;
		digit_mask_t pt;
		digit_mask_t bl;
		seg_t        exp_seg;
		logic        exp_dp;
		int          idx;
		@(negedge clk);
		if (disp_subsys_inst.digit_scanner_inst.scan_assert_inst.assert_errors != 0) begin
			report_failure("Assertions failed on the digit scanner");
		end
		// Channel 0 loads on the rising edge just passed
		if (cpu_we) begin
			m_num   = data[0];
			m_point = point_in[7:0];
			m_blink = blink_in[7:0];
		end
		cyc_since++;
		if (an_n !== prev_an) begin
			check_value("an_n rotation", {prev_an[6:0], prev_an[7]}, an_n);
			if (scan_seen) begin
				check_value("scan period", SCAN_DIV, cyc_since);
			end
			scan_seen = 1'b1;
			cyc_since = 0;
			prev_an   = an_n;
		end else if (scan_seen && cyc_since > SCAN_DIV) begin
			report_failure("The anode drive stopped advancing");
		end
		if (test_sel == 3'd0) begin
			num = m_num;
			pt  = m_point;
			bl  = m_blink;
		end else begin
			num = data[test_sel];
			pt  = point_in[test_sel*8 +: 8];
			bl  = les[test_sel*8 +: 8];
		end
		idx = low_bit_index(an_n);
		if (idx < 0) begin
			report_failure("The anode drive does not have exactly one low bit");
		end else if (bl[idx] && seg_n === 7'h7F && dp_n === 1'b1) begin
			seen_off[idx] = 1'b1;
		end else begin
			exp_seg = ~glyph_on(num[idx*4 +: 4]);
			exp_dp  = ~pt[idx];
			check_value("seg_n", exp_seg, seg_n);
			check_value("dp_n", exp_dp, dp_n);
			seen_on[idx] = 1'b1;
		end
	endtask

	task automatic random_run(int cycles, logic cpu_only);
		logic [31:0] r;
		for (int n = 0; n < cycles; n++) begin
			step();
			r = rand32();
			if (cpu_only) begin
				drive_inputs(3'd0, r[5:4] == 2'b00, 1'b0);
			end else begin
				drive_inputs(digit_idx_t'(r % 7 + 1), r[8], 1'b0);
			end
		end
	endtask

	// Masks stay fixed until every digit has shown its glyph and each blinking one went dark
	task automatic blink_run(digit_idx_t sel);
		digit_mask_t bl;
		int          n;
		drive_inputs(sel, sel == 3'd0, 1'b0);
		step();
		drive_inputs(sel, 1'b0, 1'b1);
		bl       = (sel == 3'd0) ? m_blink : les[sel*8 +: 8];
		seen_on  = '0;
		seen_off = '0;
		n = 0;
		while (!(seen_on == 8'hFF && (seen_off & bl) == bl) && n < BLINK_LIMIT) begin
			step();
			drive_inputs(sel, 1'b0, 1'b1);
			n++;
		end
		if (!(seen_on == 8'hFF && (seen_off & bl) == bl)) begin
			report_failure("Blinking digits did not show both the glyph and all-off in time");
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		lcg_state = 32'h5926;
		test_name = "reset_values";
		arst_n    = 1'b0;
		cpu_we    = 1'b0;
		test_sel  = 3'd0;
		point_in  = '0;
		blink_in  = '0;
		les       = '0;
		for (int i = 0; i < 8; i++) begin
			data[i] = '0;
		end
		m_num     = DISP_RESET_WORD;
		m_point   = POINT_RESET_MASK;
		m_blink   = BLINK_RESET_MASK;
		prev_an   = 8'b11111110;
		cyc_since = 0;
		scan_seen = 1'b0;
		seen_on   = '0;
		seen_off  = '0;
		repeat (10) @(negedge clk);
		check_value("an_n", 8'b11111110, an_n);
		drive_inputs(3'd0, 1'b0, 1'b0);
		arst_n = 1'b1;

		// Blink phase is still visible for the first full rotation
		for (int n = 0; n < 8 * SCAN_DIV; n++) begin
			step();
			drive_inputs(3'd0, 1'b0, 1'b0);
		end
		check_value("digits shown", 8'hFF, seen_on);

		test_name = "cpu_write";
		random_run(300, 1'b1);

		test_name = "channel_select";
		random_run(400, 1'b0);

		test_name = "blinking";
		blink_run(3'd0);
		blink_run(digit_idx_t'(rand32() % 7 + 1));

		if (disp_subsys_inst.digit_scanner_inst.scan_assert_inst.assert_errors == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			report_failure("Assertions failed on the digit scanner");
		end
	end

endmodule
